// File: Makefile
VERILATOR ?= verilator
TOP       ?= tb_phase_interpolator_ctrl
SEED      ?= 1176736158
OBJ_DIR   ?= obj_dir
LOG       ?= sim.log

FILELIST  := project.f
SOURCES   := $(wildcard source/*.sv) $(wildcard testbench/*.sv) $(wildcard testbench/*.svh)
BIN       := $(OBJ_DIR)/V$(TOP)

.PHONY: all run clean

all: run

$(BIN): $(FILELIST) $(SOURCES)
	$(VERILATOR) --binary --timing --top-module $(TOP) -Gseed=$(SEED) \
		--Mdir $(OBJ_DIR) -f $(FILELIST)

run: $(BIN)
	-./$(BIN) > $(LOG) 2>&1
	@cat $(LOG)
	@grep -q "sim passed" $(LOG) || (echo "no pass line found in $(LOG)"; exit 1)

clean:
	rm -rf $(OBJ_DIR) $(LOG)

// File: project.f
+incdir+testbench
source/pi_pkg.sv
source/pi_sel_if.sv
source/qperi_calibrator.sv
source/pi_code_decoder.sv
source/select_retimer.sv
source/phase_monitor.sv
source/phase_interpolator_ctrl.sv
testbench/tb_phase_interpolator_ctrl.sv

// File: source/phase_interpolator_ctrl.sv
`timescale 1ns/1ps
`default_nettype none

module phase_interpolator_ctrl #(
    parameter int n_bit     = 9,
    parameter int n_unit    = 32,
    parameter int n_blender = 4
) (
    input  logic                      and_ph_out_d,
    input  logic                      rstb,
    input  logic                      ctl_valid,
    output logic                      ctl_ready,
    input  logic [n_bit-1:0]          ctl,
    input  logic [n_unit-1:0]         arb_out,
    input  logic                      en_cal,
    input  logic                      en_ext_qperi,
    input  logic [$clog2(n_unit)-1:0] ext_qperi,
    input  logic                      sel_ready,
    output logic                      sel_valid,
    output logic [$clog2(n_unit)-1:0] sel_even,
    output logic [$clog2(n_unit)-1:0] sel_odd,
    output logic [(2**n_blender)-1:0] thm_sel_bld,
    output logic [n_unit-1:0]         en_mixer,
    output logic [$clog2(n_unit)-1:0] max_sel_mux,
    output logic [$clog2(n_unit)-1:0] qperi,
    input  logic                      en_pm,
    input  pi_pkg::pm_sign_e          sel_pm_sign,
    input  logic                      ph_lead,
    output logic [19:0]               pm_out
);
    pi_sel_if #(.n_unit(n_unit), .n_blender(n_blender)) sel_if ();

    qperi_calibrator #(.n_unit(n_unit)) i_calibrator (
        .and_ph_out_d (and_ph_out_d),
        .rstb         (rstb),
        .arb_out      (arb_out),
        .en_cal       (en_cal),
        .en_ext_qperi (en_ext_qperi),
        .ext_qperi    (ext_qperi),
        .qperi        (qperi)
    );

    pi_code_decoder #(.n_bit(n_bit), .n_unit(n_unit), .n_blender(n_blender)) i_decoder (
        .and_ph_out_d (and_ph_out_d),
        .rstb         (rstb),
        .ctl_valid    (ctl_valid),
        .ctl_ready    (ctl_ready),
        .ctl          (ctl),
        .qperi        (qperi),
        .sel          (sel_if.enc)
    );

    // Two sampling stages ahead of the mux network and blender.
    select_retimer #(.n_unit(n_unit), .n_blender(n_blender)) i_retimer (
        .and_ph_out_d (and_ph_out_d),
        .rstb         (rstb),
        .sel          (sel_if.ret),
        .sel_valid    (sel_valid),
        .sel_ready    (sel_ready),
        .sel_even     (sel_even),
        .sel_odd      (sel_odd),
        .thm_sel_bld  (thm_sel_bld),
        .en_mixer     (en_mixer),
        .max_sel_mux  (max_sel_mux)
    );

    phase_monitor i_monitor (
        .and_ph_out_d (and_ph_out_d),
        .rstb         (rstb),
        .en_pm        (en_pm),
        .sel_pm_sign  (sel_pm_sign),
        .ph_lead      (ph_lead),
        .pm_out       (pm_out)
    );

endmodule

`default_nettype wire

// File: source/phase_monitor.sv
`timescale 1ns/1ps
`default_nettype none

module phase_monitor (
    input  logic             and_ph_out_d,
    input  logic             rstb,
    input  logic             en_pm,
    input  pi_pkg::pm_sign_e sel_pm_sign,
    input  logic             ph_lead,
    output logic [19:0]      pm_out
);
    logic [19:0] delta;

    // Step applied this cycle; -1 is all ones so the sum wraps modulo 2**20.
    always_comb begin
        case (sel_pm_sign)
            pi_pkg::PM_UP: begin
                delta = ph_lead ? 20'd1 : '1;
            end
            pi_pkg::PM_DOWN: begin
                delta = ph_lead ? '1 : 20'd1;
            end
            pi_pkg::PM_COUNT: begin
                delta = {19'd0, ph_lead};
            end
            default: begin
                delta = '0;
            end
        endcase
    end

    always_ff @(posedge and_ph_out_d or negedge rstb) begin
        if (!rstb) begin
            pm_out <= '0;
        end else if (!en_pm) begin
            pm_out <= '0;
        end else begin
            pm_out <= pm_out + delta;
        end
    end

endmodule

`default_nettype wire

// File: source/pi_code_decoder.sv
`timescale 1ns/1ps
`default_nettype none

module pi_code_decoder #(
    parameter int n_bit     = 9,
    parameter int n_unit    = 32,
    parameter int n_blender = 4
) (
    input  logic                      and_ph_out_d,
    input  logic                      rstb,
    input  logic                      ctl_valid,
    output logic                      ctl_ready,
    input  logic [n_bit-1:0]          ctl,
    input  logic [$clog2(n_unit)-1:0] qperi,
    pi_sel_if.enc                     sel
);
    localparam int qw = $clog2(n_unit);
    localparam int tw = 2 ** n_blender;
    localparam int lw = qw + 4;

    logic [qw-1:0]        q_eff;
    logic [1:0]           quadrant;
    logic [2:0]           fine;
    logic [n_blender-1:0] k;
    logic [lw-1:0]        pos;
    logic [lw-1:0]        span;
    logic [qw-1:0]        d_even;
    logic [qw-1:0]        d_odd;
    logic [qw-1:0]        d_max;
    logic [tw-1:0]        d_thm;
    logic [n_unit-1:0]    d_mixer;
    logic                 accept;

    // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
    // Code fields and decode
    // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~

    assign quadrant = ctl[n_bit-1 -: 2];
    assign fine     = ctl[n_bit-3 -: 3];
    assign k        = ctl[n_blender-1:0];
    assign q_eff    = (qperi == '0) ? qw'(1) : qperi;

    // Coarse step is a whole quarter period, fine step is an eighth of one.
    assign pos  = lw'(quadrant) * lw'(q_eff) + ((lw'(fine) * lw'(q_eff)) >> 3);
    assign span = ((lw'(q_eff) << 2) < lw'(n_unit)) ? (lw'(q_eff) << 2) : lw'(n_unit);

    assign d_even = qw'(pos % lw'(n_unit));
    assign d_odd  = qw'((pos + lw'(1)) % lw'(n_unit));
    assign d_max  = qw'(span - lw'(1));

    always_comb begin
        for (int i = 0; i < tw; i++) begin
            d_thm[i] = (i < int'(k));
        end
        for (int j = 0; j < n_unit; j++) begin
            d_mixer[j] = (lw'(j) < span);
        end
    end

    // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
    // Output stage
    // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~

    assign ctl_ready = !sel.valid || sel.ready;
    assign accept    = ctl_valid && ctl_ready;

    always_ff @(posedge and_ph_out_d or negedge rstb) begin
        if (!rstb) begin
            sel.valid <= 1'b0;
        end else if (accept) begin
            sel.valid <= 1'b1;
        end else if (sel.ready) begin
            sel.valid <= 1'b0;
        end
    end

    always_ff @(posedge and_ph_out_d) begin
        if (accept) begin
            sel.sel_even    <= d_even;
            sel.sel_odd     <= d_odd;
            sel.thm_sel_bld <= d_thm;
            sel.en_mixer    <= d_mixer;
            sel.max_sel_mux <= d_max;
        end
    end

    a_odd_follows_even: assert property (
        @(posedge and_ph_out_d) disable iff (!rstb)
        sel.valid |-> sel.sel_odd == qw'((int'(sel.sel_even) + 1) % n_unit)
    ) else $error("sel_odd does not follow sel_even");

endmodule

`default_nettype wire

// File: source/pi_pkg.sv
`default_nettype none

package pi_pkg;

    // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
    // Quarter-period calibration
    // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~

    // Calibrator FSM states.
    typedef enum logic [1:0] {
        CAL_IDLE   = 2'd0,
        CAL_TRACK  = 2'd1,
        CAL_LOCKED = 2'd2
    } cal_state_e;

    // Number of equal consecutive popcounts before qperi is rewritten.
    parameter int unsigned cal_repeat = 4;

    // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
    // Phase monitor
    // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~

    // Sign select of the lead/lag accumulator.
    // PM_UP counts +1 on lead and -1 on lag, PM_DOWN the reverse.
    typedef enum logic [1:0] {
        PM_HOLD  = 2'd0,
        PM_UP    = 2'd1,
        PM_DOWN  = 2'd2,
        PM_COUNT = 2'd3
    } pm_sign_e;

endpackage

`default_nettype wire

// File: source/pi_sel_if.sv
`timescale 1ns/1ps
`default_nettype none

// Decoded selects travelling from the code decoder to the retimer.
interface pi_sel_if #(
    parameter int n_unit    = 32,
    parameter int n_blender = 4
);
    logic                        valid;
    logic                        ready;
    logic [$clog2(n_unit)-1:0]   sel_even;
    logic [$clog2(n_unit)-1:0]   sel_odd;
    logic [(2**n_blender)-1:0]   thm_sel_bld;
    logic [n_unit-1:0]           en_mixer;
    logic [$clog2(n_unit)-1:0]   max_sel_mux;

    modport enc (
        input  ready,
        output valid, sel_even, sel_odd, thm_sel_bld, en_mixer, max_sel_mux
    );

    modport ret (
        output ready,
        input  valid, sel_even, sel_odd, thm_sel_bld, en_mixer, max_sel_mux
    );

endinterface

`default_nettype wire

// File: source/qperi_calibrator.sv
`timescale 1ns/1ps
`default_nettype none

module qperi_calibrator #(
    parameter int n_unit = 32
) (
    input  logic                      and_ph_out_d,
    input  logic                      rstb,
    input  logic [n_unit-1:0]         arb_out,
    input  logic                      en_cal,
    input  logic                      en_ext_qperi,
    input  logic [$clog2(n_unit)-1:0] ext_qperi,
    output logic [$clog2(n_unit)-1:0] qperi
);
    localparam int qw    = $clog2(n_unit);
    localparam int pc_w  = $clog2(n_unit + 1);
    localparam int rep_w = $clog2(pi_pkg::cal_repeat + 1);

    pi_pkg::cal_state_e state;
    logic [pc_w-1:0]    pc;
    logic [pc_w-1:0]    last_pc;
    logic [rep_w-1:0]   rep_cnt;
    logic [qw-1:0]      pc_clamped;
    logic [qw-1:0]      ext_clamped;
    logic               same;
    logic               hit;

    // Number of delay units the arbiter saw inside a quarter period.
    always_comb begin
        pc = '0;
        for (int i = 0; i < n_unit; i++) begin
            pc = pc + pc_w'(arb_out[i]);
        end
    end

    // Keep qperi inside 1..n_unit-1 so the decoder always has a usable span.
    assign pc_clamped  = (pc == '0) ? qw'(1) :
                         (pc > pc_w'(n_unit - 1)) ? qw'(n_unit - 1) : qw'(pc);
    assign ext_clamped = (ext_qperi == '0) ? qw'(1) : ext_qperi;

    assign same = (state != pi_pkg::CAL_IDLE) && (pc == last_pc);
    assign hit  = en_cal && (state == pi_pkg::CAL_TRACK) && same &&
                  (rep_cnt == rep_w'(pi_pkg::cal_repeat - 1));

    always_ff @(posedge and_ph_out_d or negedge rstb) begin
        if (!rstb) begin
            state   <= pi_pkg::CAL_IDLE;
            last_pc <= '0;
            rep_cnt <= '0;
        end else if (!en_cal) begin
            state   <= pi_pkg::CAL_IDLE;
            rep_cnt <= '0;
        end else begin
            last_pc <= pc;
            case (state)
                pi_pkg::CAL_IDLE: begin
                    state   <= pi_pkg::CAL_TRACK;
                    rep_cnt <= rep_w'(1);
                end
                pi_pkg::CAL_TRACK: begin
                    if (!same) begin
                        rep_cnt <= rep_w'(1);
                    end else if (hit) begin
                        state <= pi_pkg::CAL_LOCKED;
                    end else begin
                        rep_cnt <= rep_cnt + rep_w'(1);
                    end
                end
                default: begin
                    if (!same) begin
                        state   <= pi_pkg::CAL_TRACK;
                        rep_cnt <= rep_w'(1);
                    end
                end
            endcase
        end
    end

    // The override wins over a calibration result in the same cycle.
    always_ff @(posedge and_ph_out_d or negedge rstb) begin
        if (!rstb) begin
            qperi <= qw'(n_unit / 4);
        end else if (en_ext_qperi) begin
            qperi <= ext_clamped;
        end else if (hit) begin
            qperi <= pc_clamped;
        end
    end

    a_qperi_nonzero: assert property (
        @(posedge and_ph_out_d) disable iff (!rstb) qperi != '0
    ) else $error("qperi reached zero");

endmodule

`default_nettype wire

// File: source/select_retimer.sv
`timescale 1ns/1ps
`default_nettype none

module select_retimer #(
    parameter int n_unit    = 32,
    parameter int n_blender = 4
) (
    input  logic                      and_ph_out_d,
    input  logic                      rstb,
    pi_sel_if.ret                     sel,
    output logic                      sel_valid,
    input  logic                      sel_ready,
    output logic [$clog2(n_unit)-1:0] sel_even,
    output logic [$clog2(n_unit)-1:0] sel_odd,
    output logic [(2**n_blender)-1:0] thm_sel_bld,
    output logic [n_unit-1:0]         en_mixer,
    output logic [$clog2(n_unit)-1:0] max_sel_mux
);
    localparam int qw = $clog2(n_unit);
    localparam int dw = 3 * qw + (2 ** n_blender) + n_unit;

    logic [dw-1:0] in_data;
    logic [dw-1:0] out_q;
    logic [dw-1:0] skid_q;
    logic          out_valid;
    logic          skid_valid;
    logic          push;
    logic          pop;

    assign in_data = {sel.sel_even, sel.sel_odd, sel.thm_sel_bld, sel.en_mixer, sel.max_sel_mux};
    assign {sel_even, sel_odd, thm_sel_bld, en_mixer, max_sel_mux} = out_q;

    // The second entry only fills while the output entry is stalled.
    assign sel.ready = !skid_valid;
    assign sel_valid = out_valid;
    assign push      = sel.valid && sel.ready;
    assign pop       = out_valid && sel_ready;

    always_ff @(posedge and_ph_out_d or negedge rstb) begin
        if (!rstb) begin
            out_valid  <= 1'b0;
            skid_valid <= 1'b0;
        end else if (pop) begin
            if (skid_valid) begin
                skid_valid <= 1'b0;
            end else if (!push) begin
                out_valid <= 1'b0;
            end
        end else if (push) begin
            if (!out_valid) begin
                out_valid <= 1'b1;
            end else begin
                skid_valid <= 1'b1;
            end
        end
    end

    always_ff @(posedge and_ph_out_d) begin
        if (pop) begin
            if (skid_valid) begin
                out_q <= skid_q;
            end else if (push) begin
                out_q <= in_data;
            end
        end else if (push) begin
            if (!out_valid) begin
                out_q <= in_data;
            end else begin
                skid_q <= in_data;
            end
        end
    end

    a_hold_on_stall: assert property (
        @(posedge and_ph_out_d) disable iff (!rstb)
        sel_valid && !sel_ready |=> sel_valid && $stable(out_q)
    ) else $error("select output changed while stalled");

endmodule

`default_nettype wire

// File: testbench/pi_ref_model.svh
`ifndef PI_REF_MODEL_SVH
`define PI_REF_MODEL_SVH

// Expected fields of one decoded phase code, in the order of the top-level outputs.
typedef struct packed {
    logic [qw-1:0]     even;
    logic [qw-1:0]     odd;
    logic [tw-1:0]     thm;
    logic [n_unit-1:0] mixer;
    logic [qw-1:0]     max_sel;
} sel_exp_t;

function automatic sel_exp_t ref_decode(input logic [n_bit-1:0] c, input logic [qw-1:0] q_in);
    sel_exp_t r;
    int       q;
    int       quadrant;
    int       fine;
    int       k;
    int       span;
    int       even;
    q = int'(q_in);
    if (q == 0) begin
        q = 1;
    end
    quadrant = int'(c[n_bit-1 -: 2]);
    fine     = int'(c[n_bit-3 -: 3]);
    k        = int'(c[n_blender-1:0]);
    even     = (quadrant * q + (fine * q) / 8) % n_unit;
    span     = (4 * q < n_unit) ? 4 * q : n_unit;
    r.even    = qw'(even);
    r.odd     = qw'((even + 1) % n_unit);
    r.max_sel = qw'(span - 1);
    for (int i = 0; i < tw; i++) begin
        r.thm[i] = (i < k);
    end
    for (int j = 0; j < n_unit; j++) begin
        r.mixer[j] = (j < span);
    end
    return r;
endfunction

// A full delay line saturates at n_unit-1, since qperi is only qw bits wide.
function automatic logic [qw-1:0] ref_cal_q(input logic [n_unit-1:0] arb);
    int n;
    n = 0;
    for (int i = 0; i < n_unit; i++) begin
        if (arb[i]) begin
            n++;
        end
    end
    if (n < 1) begin
        n = 1;
    end
    if (n > n_unit - 1) begin
        n = n_unit - 1;
    end
    return qw'(n);
endfunction

function automatic logic [qw-1:0] ref_ext_q(input logic [qw-1:0] ext);
    return (ext == '0) ? qw'(1) : ext;
endfunction

function automatic logic [19:0] ref_pm_next(input logic [19:0] acc, input logic en,
                                            input pi_pkg::pm_sign_e sign, input logic lead);
    if (!en) begin
        return '0;
    end
    case (sign)
        pi_pkg::PM_UP:    return lead ? acc + 20'd1 : acc - 20'd1;
        pi_pkg::PM_DOWN:  return lead ? acc - 20'd1 : acc + 20'd1;
        pi_pkg::PM_COUNT: return lead ? acc + 20'd1 : acc;
        default:          return acc;
    endcase
endfunction

`endif

// File: testbench/tb_phase_interpolator_ctrl.sv
`timescale 1ns/1ps
`default_nettype none

module tb_phase_interpolator_ctrl #(
    parameter logic [31:0] seed = 32'h4623_919e
);
    localparam int n_bit      = 9;
    localparam int n_unit     = 32;
    localparam int n_blender  = 4;
    localparam int qw         = $clog2(n_unit);
    localparam int tw         = 2 ** n_blender;
    localparam int max_cycles = 4000;

    `include "pi_ref_model.svh"

    logic                and_ph_out_d;
    logic                rstb;
    logic                ctl_valid;
    logic                ctl_ready;
    logic [n_bit-1:0]    ctl;
    logic [n_unit-1:0]   arb_out;
    logic                en_cal;
    logic                en_ext_qperi;
    logic [qw-1:0]       ext_qperi;
    logic                sel_ready;
    logic                sel_valid;
    logic [qw-1:0]       sel_even;
    logic [qw-1:0]       sel_odd;
    logic [tw-1:0]       thm_sel_bld;
    logic [n_unit-1:0]   en_mixer;
    logic [qw-1:0]       max_sel_mux;
    logic [qw-1:0]       qperi;
    logic                en_pm;
    pi_pkg::pm_sign_e    sel_pm_sign;
    logic                ph_lead;
    logic [19:0]         pm_out;

    sel_exp_t            exp_q[$];
    int                  acc_cycle_q[$];
    logic [qw-1:0]       model_q;
    logic [19:0]         pm_model;
    int                  cycle;
    logic                check_latency;
    logic                random_ready;
    logic                stalled;
    sel_exp_t            held;

    phase_interpolator_ctrl #(.n_bit(n_bit), .n_unit(n_unit), .n_blender(n_blender)) u_dut (
        .and_ph_out_d (and_ph_out_d),
        .rstb         (rstb),
        .ctl_valid    (ctl_valid),
        .ctl_ready    (ctl_ready),
        .ctl          (ctl),
        .arb_out      (arb_out),
        .en_cal       (en_cal),
        .en_ext_qperi (en_ext_qperi),
        .ext_qperi    (ext_qperi),
        .sel_ready    (sel_ready),
        .sel_valid    (sel_valid),
        .sel_even     (sel_even),
        .sel_odd      (sel_odd),
        .thm_sel_bld  (thm_sel_bld),
        .en_mixer     (en_mixer),
        .max_sel_mux  (max_sel_mux),
        .qperi        (qperi),
        .en_pm        (en_pm),
        .sel_pm_sign  (sel_pm_sign),
        .ph_lead      (ph_lead),
        .pm_out       (pm_out)
    );

    always #10 and_ph_out_d = !and_ph_out_d;

    always @(posedge and_ph_out_d) begin
        cycle <= cycle + 1;
        if (cycle >= max_cycles) begin
            stop_with_failure("timeout, the run did not finish within the cycle limit");
        end
    end

    // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
    // Checking helpers
    // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~

    task automatic stop_with_failure(input string what);
        $display("%s", what);
        $display("sim failed");
        $fatal(1, "run stopped at %0t", $time);
    endtask

    task automatic check_value(input string name, input logic [63:0] exp, input logic [63:0] act);
        assert (act == exp) else stop_with_failure(
            $sformatf("ERR %0t %s expected %0h actual %0h", $time, name, exp, act));
    endtask

    task automatic compare_fields(input sel_exp_t e);
        check_value("sel_even", 64'(e.even), 64'(sel_even));
        check_value("sel_odd", 64'(e.odd), 64'(sel_odd));
        check_value("thm_sel_bld", 64'(e.thm), 64'(thm_sel_bld));
        check_value("en_mixer", 64'(e.mixer), 64'(en_mixer));
        check_value("max_sel_mux", 64'(e.max_sel), 64'(max_sel_mux));
    endtask

    // Handshakes are sampled mid-cycle, where they hold the values seen by the next edge.
    always @(negedge and_ph_out_d) begin
        if (rstb && ctl_valid && ctl_ready) begin
            exp_q.push_back(ref_decode(ctl, model_q));
            acc_cycle_q.push_back(cycle);
        end
    end

    always @(negedge and_ph_out_d) begin
        sel_exp_t e;
        int       lat;
        if (rstb) begin
            if (stalled) begin
                assert (sel_valid) else stop_with_failure("sel_valid dropped during a stall");
                compare_fields(held);
            end
            if (sel_valid && sel_ready) begin
                assert (exp_q.size() > 0) else stop_with_failure("select transfer with no code");
                e   = exp_q.pop_front();
                lat = cycle - acc_cycle_q.pop_front();
                compare_fields(e);
                if (check_latency) begin
                    check_value("latency", 64'(2), 64'(lat));
                end
            end
            stalled = sel_valid && !sel_ready;
            held    = {sel_even, sel_odd, thm_sel_bld, en_mixer, max_sel_mux};
        end
    end

    always @(posedge and_ph_out_d) begin
        pm_model <= rstb ? ref_pm_next(pm_model, en_pm, sel_pm_sign, ph_lead) : 20'd0;
    end

    always @(negedge and_ph_out_d) begin
        if (rstb) begin
            check_value("pm_out", 64'(pm_model), 64'(pm_out));
        end
    end

    always @(posedge and_ph_out_d) begin
        #2;
        if (random_ready) begin
            sel_ready = 1'($urandom_range(0, 1));
        end
    end

    // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
    // Stimulus
    // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~

    function automatic logic [n_unit-1:0] thermometer(input int n);
        logic [n_unit-1:0] t;
        for (int j = 0; j < n_unit; j++) begin
            t[j] = (j < n);
        end
        return t;
    endfunction

    task automatic next_cycle();
        @(posedge and_ph_out_d);
        #2;
    endtask

    task automatic send_code(input logic [n_bit-1:0] code);
        ctl_valid = 1'b1;
        ctl       = code;
        @(negedge and_ph_out_d);
        while (!ctl_ready) begin
            @(negedge and_ph_out_d);
        end
        next_cycle();
        ctl_valid = 1'b0;
    endtask

    task automatic stream_codes(input int count);
        repeat (count) begin
            send_code(n_bit'($urandom));
        end
    endtask

    task automatic drain();
        while (exp_q.size() != 0) begin
            @(negedge and_ph_out_d);
        end
        next_cycle();
    endtask

    // Four equal samples update qperi, six give margin after the lock.
    task automatic calibrate(input logic [n_unit-1:0] arb);
        arb_out = arb;
        en_cal  = 1'b1;
        repeat (6) @(posedge and_ph_out_d);
        #2;
        en_cal  = 1'b0;
        model_q = ref_cal_q(arb);
        @(negedge and_ph_out_d);
        check_value("qperi", 64'(model_q), 64'(qperi));
        next_cycle();
    endtask

    task automatic override_qperi(input logic [qw-1:0] ext);
        ext_qperi    = ext;
        en_ext_qperi = 1'b1;
        next_cycle();
        en_ext_qperi = 1'b0;
        model_q      = ref_ext_q(ext);
        @(negedge and_ph_out_d);
        check_value("qperi", 64'(model_q), 64'(qperi));
        next_cycle();
    endtask

    task automatic run_opcode(input pi_pkg::pm_sign_e op, input int count, input int lead);
        sel_pm_sign = op;
        repeat (count) begin
            ph_lead = (lead < 0) ? 1'($urandom_range(0, 1)) : 1'(lead);
            next_cycle();
        end
    endtask

    initial begin
        void'($urandom(seed));
        and_ph_out_d  = 1'b0;
        rstb          = 1'b0;
        ctl_valid     = 1'b0;
        ctl           = '0;
        arb_out       = '0;
        en_cal        = 1'b0;
        en_ext_qperi  = 1'b0;
        ext_qperi     = '0;
        sel_ready     = 1'b1;
        en_pm         = 1'b0;
        sel_pm_sign   = pi_pkg::PM_HOLD;
        ph_lead       = 1'b0;
        cycle         = 0;
        model_q       = qw'(n_unit / 4);
        pm_model      = '0;
        check_latency = 1'b1;
        random_ready  = 1'b0;
        stalled       = 1'b0;
        held          = '0;
        repeat (16) @(posedge and_ph_out_d);
        #2;
        rstb = 1'b1;

        @(negedge and_ph_out_d);
        check_value("qperi", 64'(qw'(n_unit / 4)), 64'(qperi));
        check_value("sel_valid", 64'(0), 64'(sel_valid));
        check_value("ctl_ready", 64'(1), 64'(ctl_ready));
        next_cycle();

        stream_codes(200);
        drain();

        calibrate(thermometer(int'($urandom_range(1, n_unit - 1))));
        stream_codes(20);
        calibrate(thermometer(int'($urandom_range(0, n_unit))));
        stream_codes(20);
        calibrate(thermometer(0));
        stream_codes(10);
        calibrate(thermometer(n_unit));
        stream_codes(10);
        override_qperi(qw'($urandom));
        stream_codes(20);
        override_qperi('0);
        stream_codes(10);
        drain();

        check_latency = 1'b0;
        random_ready  = 1'b1;
        stream_codes(400);
        drain();
        random_ready  = 1'b0;
        sel_ready     = 1'b1;

        en_pm = 1'b1;
        run_opcode(pi_pkg::PM_UP, 40, -1);
        run_opcode(pi_pkg::PM_DOWN, 40, -1);
        run_opcode(pi_pkg::PM_COUNT, 40, -1);
        run_opcode(pi_pkg::PM_HOLD, 20, -1);
        en_pm = 1'b0;
        next_cycle();
        en_pm = 1'b1;
        // Counting down past zero, then up again, crosses the wrap point both ways.
        run_opcode(pi_pkg::PM_UP, 5, 0);
        run_opcode(pi_pkg::PM_COUNT, 10, 1);
        @(negedge and_ph_out_d);
        check_value("pm_out", 64'(20'd5), 64'(pm_out));
        next_cycle();
        en_pm = 1'b0;
        next_cycle();

        @(negedge and_ph_out_d);
        if (exp_q.size() == 0 && pm_out == 20'd0) begin
            $display("sim passed");
            $finish;
        end else begin
            stop_with_failure("codes left unmatched or pm_out not cleared at the end");
        end
    end

endmodule

`default_nettype wire
